//--- src/databuf_pkg.sv
package databuf_pkg;

    // ----------------------------------------------------------------------
    // host register bus address map
    // ----------------------------------------------------------------------

    // top nibble of the main register block
    localparam logic [3:0] addr_main = 4'h0;
    // low nibble of the command register
    localparam logic [3:0] off_dac_ctrl = 4'h1;
    // command word bit that starts or stops collection
    localparam int run_bit = 30;

    // raddr[15] value that selects register space over memory
    localparam logic rd_status_sel = 1'b1;
    // status word offset inside register space
    localparam logic [11:0] status_offset = 12'h000;

    // ----------------------------------------------------------------------
    // buffer layout and word formats
    // ----------------------------------------------------------------------

    // four data channels plus the timestamp channel
    localparam int num_chan = 5;
    // buffer_source codes from here up are encoder readings
    localparam logic [3:0] src_enc_first = 4'd4;
    // stored timestamp bits below the overflow flag
    localparam int ts_low_w = 14;

    typedef enum logic {kind_cmd, kind_sample} word_kind_t;

endpackage

//--- src/buffer_ctrl.sv
`timescale 1ns/100ps

module buffer_ctrl #(
    parameter int buf_aw = 10
) (
    input  logic                    clkbuffer,
    input  logic                    rst_n,
    input  logic                    reg_wen,
    input  logic [15:0]             reg_waddr,
    input  logic [31:0]             reg_wdata,
    input  logic                    data_fb_wen,
    output logic                    capture,
    output databuf_pkg::word_kind_t kind,
    output logic [15:0]             cmd_value,
    output logic                    buf_wen,
    output logic [buf_aw-1:0]       buf_waddr,
    output logic                    collecting
);
    import databuf_pkg::*;

    logic cmd_wen;
    logic run_req;
    logic fb_last;
    logic fb_trigger;
    logic pending;

    // ----------------------------------------------------------------------
    // decode and edge detect
    // ----------------------------------------------------------------------

    // command register write on the main block
    assign cmd_wen = reg_wen && (reg_waddr[15:12] == addr_main)
                     && (reg_waddr[3:0] == off_dac_ctrl);
    assign run_req = reg_wdata[run_bit];

    // rising edge of the feedback ready strobe
    assign fb_trigger = data_fb_wen && !fb_last;

    // a command always wins the cycle, a sample waits in pending
    // a stop command has no word to store
    assign capture = cmd_wen ? run_req : ((collecting && fb_trigger) || pending);
    assign kind = cmd_wen ? kind_cmd : kind_sample;
    assign cmd_value = reg_wdata[15:0];

    // ----------------------------------------------------------------------
    // collection state and shared write address
    // ----------------------------------------------------------------------

    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            collecting <= 1'b0;
            pending <= 1'b0;
            fb_last <= 1'b0;
            buf_wen <= 1'b0;
            buf_waddr <= '0;
        end else begin
            fb_last <= data_fb_wen;
            if (cmd_wen) begin
                // start restarts the buffer at word 0
                if (!collecting && run_req) begin
                    buf_waddr <= '0;
                end else begin
                    // advance only if collection keeps running
                    buf_waddr <= buf_waddr + buf_aw'(run_req);
                end
                collecting <= run_req;
                buf_wen <= run_req;
                // feedback edge lost to the command, store it next cycle
                if (run_req && fb_trigger) begin
                    pending <= 1'b1;
                end else if (!run_req) begin
                    // stopped, so a held sample is dropped
                    pending <= 1'b0;
                end
            end else if ((collecting && fb_trigger) || pending) begin
                // sample goes to the next word, wraps with the counter width
                buf_waddr <= buf_waddr + 1'b1;
                buf_wen <= 1'b1;
                pending <= 1'b0;
            end else begin
                buf_wen <= 1'b0;
            end
        end
    end

    // every memory write comes from a word the packer registered
    a_wen_after_capture: assert property (
        @(posedge clkbuffer) disable iff (!rst_n)
        $rose(buf_wen) |-> $past(capture)
    );

    // a held sample only exists during collection
    a_pending_collecting: assert property (
        @(posedge clkbuffer) disable iff (!rst_n)
        pending |-> collecting
    );

endmodule

//--- src/sample_packer.sv
`timescale 1ns/100ps

module sample_packer (
    input  logic                    clkbuffer,
    input  logic                    rst_n,
    input  logic                    capture,
    input  databuf_pkg::word_kind_t kind,
    input  logic [15:0]             cmd_value,
    input  logic [31:0]             ts,
    input  logic [3:0]              buffer_source,
    input  logic [31:0]             input_data1,
    input  logic [31:0]             input_data2,
    input  logic [31:0]             input_data3,
    input  logic [31:0]             input_data4,
    output logic [31:0]             wdata1,
    output logic [31:0]             wdata2,
    output logic [31:0]             wdata3,
    output logic [31:0]             wdata4,
    output logic [31:0]             wdata5
);
    import databuf_pkg::*;

    logic              ts_over14;
    logic [ts_low_w:0] stamp;
    logic              enc_mode;

    // flag set once the timestamp no longer fits the stored field
    assign ts_over14 = |ts[31:ts_low_w];
    assign stamp = {ts_over14, ts[ts_low_w-1:0]};
    // encoder sources keep raw 32 bit readings
    assign enc_mode = (buffer_source >= src_enc_first);

    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            wdata1 <= '0;
            wdata2 <= '0;
            wdata3 <= '0;
            wdata4 <= '0;
            wdata5 <= '0;
        end else if (capture) begin
            if (kind == kind_cmd) begin
                // command value with bit 31 clear on every channel
                wdata1 <= {1'b0, stamp, cmd_value};
                wdata2 <= {1'b0, stamp, cmd_value};
                wdata3 <= {1'b0, stamp, cmd_value};
                wdata4 <= {1'b0, stamp, cmd_value};
                wdata5 <= {1'b0, stamp, cmd_value};
            end else if (!enc_mode) begin
                // pot/current readings carry the stamp in the high half
                wdata1 <= {1'b1, stamp, input_data1[15:0]};
                wdata2 <= {1'b1, stamp, input_data2[15:0]};
                wdata3 <= {1'b1, stamp, input_data3[15:0]};
                wdata4 <= {1'b1, stamp, input_data4[15:0]};
                wdata5 <= '0;
            end else begin
                // encoder readings are full width, stamp moves to channel 5
                wdata1 <= input_data1;
                wdata2 <= input_data2;
                wdata3 <= input_data3;
                wdata4 <= input_data4;
                wdata5 <= {1'b1, stamp, 16'h0000};
            end
        end
    end

endmodule

//--- src/sample_ram.sv
`timescale 1ns/100ps

module sample_ram #(
    parameter int buf_aw = 10
) (
    input  logic              clkbuffer,
    input  logic              wen,
    input  logic [buf_aw-1:0] waddr,
    input  logic [31:0]       wdata,
    input  logic [buf_aw-1:0] raddr,
    output logic [31:0]       rdata
);

    // one channel of the capture buffer
    logic [31:0] mem [2**buf_aw];

    // write port from the collection side
    always_ff @(posedge clkbuffer) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // host read port, data one cycle after the address
    always_ff @(posedge clkbuffer) begin
        rdata <= mem[raddr];
    end

    // a write must land on a known word
    a_waddr_known: assert property (
        @(posedge clkbuffer) wen |-> !$isunknown(waddr)
    );

endmodule

//--- src/readback_mux.sv
`timescale 1ns/100ps

module readback_mux #(
    parameter int buf_aw = 10
) (
    input  logic              clkbuffer,
    input  logic              rst_n,
    input  logic [15:0]       reg_raddr,
    input  logic [31:0]       rd_data1,
    input  logic [31:0]       rd_data2,
    input  logic [31:0]       rd_data3,
    input  logic [31:0]       rd_data4,
    input  logic [31:0]       rd_data5,
    input  logic              collecting,
    input  logic [buf_aw-1:0] buf_waddr,
    output logic [buf_aw-1:0] rd_addr,
    output logic [31:0]       reg_rdata,
    output logic [15:0]       databuf_status
);
    import databuf_pkg::*;

    logic [15:0] status_word;
    logic [31:0] mem_word [num_chan];
    logic [31:0] mem_sel;
    logic        reg_space_q;
    logic [2:0]  chan_q;
    logic [31:0] reg_word_q;

    // word address goes straight to all channel memories
    assign rd_addr = reg_raddr[buf_aw-1:0];

    // run flag on top, write pointer zero extended below
    assign status_word = {collecting, {(15-buf_aw){1'b0}}, buf_waddr};
    assign databuf_status = status_word;

    assign mem_word[0] = rd_data1;
    assign mem_word[1] = rd_data2;
    assign mem_word[2] = rd_data3;
    assign mem_word[3] = rd_data4;
    assign mem_word[4] = rd_data5;

    // ----------------------------------------------------------------------
    // decode registered alongside the memory read
    // ----------------------------------------------------------------------

    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            // register space miss reads back as zero
            reg_space_q <= 1'b1;
            chan_q <= '0;
            reg_word_q <= '0;
        end else begin
            reg_space_q <= (reg_raddr[15] == rd_status_sel);
            chan_q <= reg_raddr[14:12];
            // only the status offset is mapped in register space
            if (reg_raddr[11:0] == status_offset) begin
                reg_word_q <= {16'h0000, status_word};
            end else begin
                reg_word_q <= '0;
            end
        end
    end

    // unused channel indexes read as zero
    always_comb begin
        mem_sel = '0;
        if (int'(chan_q) < num_chan) begin
            mem_sel = mem_word[chan_q];
        end
    end

    assign reg_rdata = reg_space_q ? reg_word_q : mem_sel;

endmodule

//--- src/data_buffer_top.sv
`timescale 1ns/100ps

module data_buffer_top #(
    parameter int buf_aw = 10
) (
    input  logic        clkbuffer,
    input  logic        rst_n,
    input  logic [31:0] ts,
    input  logic        data_fb_wen,
    input  logic [31:0] input_data1,
    input  logic [31:0] input_data2,
    input  logic [31:0] input_data3,
    input  logic [31:0] input_data4,
    input  logic [3:0]  buffer_source,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [15:0] reg_raddr,
    output logic [31:0] reg_rdata,
    output logic [15:0] databuf_status
);
    import databuf_pkg::*;

    // control to packer
    logic        capture;
    word_kind_t  kind;
    logic [15:0] cmd_value;
    // shared write port of all channels
    logic              buf_wen;
    logic [buf_aw-1:0] buf_waddr;
    logic              collecting;
    logic [31:0]       wdata1, wdata2, wdata3, wdata4, wdata5;
    // shared read port
    logic [buf_aw-1:0] rd_addr;
    logic [31:0]       rd_data1, rd_data2, rd_data3, rd_data4, rd_data5;

    // ----------------------------------------------------------------------
    // collection control and word formatting
    // ----------------------------------------------------------------------

    buffer_ctrl #(.buf_aw(buf_aw)) i_buffer_ctrl (
        .clkbuffer(clkbuffer), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .data_fb_wen(data_fb_wen),
        .capture(capture), .kind(kind), .cmd_value(cmd_value),
        .buf_wen(buf_wen), .buf_waddr(buf_waddr), .collecting(collecting)
    );

    sample_packer i_sample_packer (
        .clkbuffer(clkbuffer), .rst_n(rst_n),
        .capture(capture), .kind(kind), .cmd_value(cmd_value),
        .ts(ts), .buffer_source(buffer_source),
        .input_data1(input_data1), .input_data2(input_data2),
        .input_data3(input_data3), .input_data4(input_data4),
        .wdata1(wdata1), .wdata2(wdata2), .wdata3(wdata3),
        .wdata4(wdata4), .wdata5(wdata5)
    );

    // ----------------------------------------------------------------------
    // channel memories, channel 5 holds the encoder timestamp
    // ----------------------------------------------------------------------

    sample_ram #(.buf_aw(buf_aw)) i_ram_chan1 (
        .clkbuffer(clkbuffer), .wen(buf_wen), .waddr(buf_waddr),
        .wdata(wdata1), .raddr(rd_addr), .rdata(rd_data1)
    );
    sample_ram #(.buf_aw(buf_aw)) i_ram_chan2 (
        .clkbuffer(clkbuffer), .wen(buf_wen), .waddr(buf_waddr),
        .wdata(wdata2), .raddr(rd_addr), .rdata(rd_data2)
    );
    sample_ram #(.buf_aw(buf_aw)) i_ram_chan3 (
        .clkbuffer(clkbuffer), .wen(buf_wen), .waddr(buf_waddr),
        .wdata(wdata3), .raddr(rd_addr), .rdata(rd_data3)
    );
    sample_ram #(.buf_aw(buf_aw)) i_ram_chan4 (
        .clkbuffer(clkbuffer), .wen(buf_wen), .waddr(buf_waddr),
        .wdata(wdata4), .raddr(rd_addr), .rdata(rd_data4)
    );
    sample_ram #(.buf_aw(buf_aw)) i_ram_chan5 (
        .clkbuffer(clkbuffer), .wen(buf_wen), .waddr(buf_waddr),
        .wdata(wdata5), .raddr(rd_addr), .rdata(rd_data5)
    );

    // host readback and status
    readback_mux #(.buf_aw(buf_aw)) i_readback_mux (
        .clkbuffer(clkbuffer), .rst_n(rst_n), .reg_raddr(reg_raddr),
        .rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
        .rd_data4(rd_data4), .rd_data5(rd_data5),
        .collecting(collecting), .buf_waddr(buf_waddr),
        .rd_addr(rd_addr), .reg_rdata(reg_rdata), .databuf_status(databuf_status)
    );

endmodule

//--- testbench/databuf_checker.sv
`timescale 1ns/100ps

module databuf_checker #(
    parameter int buf_aw = 10
) (
    input  logic        clkbuffer,
    input  logic        rst_n,
    input  logic [31:0] ts,
    input  logic        data_fb_wen,
    input  logic [31:0] input_data1,
    input  logic [31:0] input_data2,
    input  logic [31:0] input_data3,
    input  logic [31:0] input_data4,
    input  logic [3:0]  buffer_source,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [15:0] reg_raddr,
    input  logic [31:0] reg_rdata,
    input  logic [15:0] databuf_status,
    output int          errors,
    output int          checked
);
    import databuf_pkg::*;

    localparam int depth = 2**buf_aw;

    // reference copy of all channel memories
    logic [31:0]       model_mem [num_chan][depth];
    bit                word_known [depth];
    bit                m_collecting;
    bit                m_pending;
    bit                m_fb_last;
    logic [buf_aw-1:0] m_addr = '0;
    // word captured at one edge lands in memory at the next
    bit                stage_wen;
    logic [buf_aw-1:0] stage_addr;
    logic [31:0]       stage_word [num_chan];
    // read result due after the last edge
    bit                exp_valid;
    logic [31:0]       exp_rdata;
    logic [15:0]       exp_raddr;
    int                mismatches = 0;
    int                reads_done = 0;

    assign errors = mismatches;
    assign checked = reads_done;

    function automatic logic [15:0] status_of(bit run, logic [buf_aw-1:0] ptr);
        logic [15:0] st;
        st = '0;
        st[15] = run;
        st[buf_aw-1:0] = ptr;
        return st;
    endfunction

    // ----------------------------------------------------------------------
    // reference model, one step per rising edge
    // ----------------------------------------------------------------------

    always @(posedge clkbuffer) begin
        logic              cmd_wr;
        logic              run;
        logic              trig;
        logic              take_sample;
        logic              enc;
        logic [ts_low_w:0] stamp;
        logic [31:0]       fb_in [4];

        cmd_wr = reg_wen && (reg_waddr[15:12] == addr_main) && (reg_waddr[3:0] == off_dac_ctrl);
        run = reg_wdata[run_bit];
        trig = data_fb_wen && !m_fb_last;
        take_sample = !cmd_wr && ((m_collecting && trig) || m_pending);
        enc = (buffer_source >= src_enc_first);
        stamp = {(ts[31:ts_low_w] != '0), ts[ts_low_w-1:0]};
        fb_in = '{input_data1, input_data2, input_data3, input_data4};

        // read sees memory before this edge's write
        exp_raddr = reg_raddr;
        exp_valid = rst_n;
        exp_rdata = '0;
        if (reg_raddr[15] == rd_status_sel) begin
            if (reg_raddr[11:0] == status_offset) begin
                exp_rdata = {16'h0000, status_of(m_collecting, m_addr)};
            end
        end else if (int'(reg_raddr[14:12]) < num_chan) begin
            exp_valid = rst_n && word_known[reg_raddr[buf_aw-1:0]];
            exp_rdata = model_mem[reg_raddr[14:12]][reg_raddr[buf_aw-1:0]];
        end

        if (stage_wen) begin
            for (int ch = 0; ch < num_chan; ch++) begin
                model_mem[ch][stage_addr] = stage_word[ch];
            end
            word_known[stage_addr] = 1'b1;
        end
        stage_wen = 1'b0;

        if (!rst_n) begin
            m_collecting = 1'b0;
            m_pending = 1'b0;
            m_fb_last = 1'b0;
            m_addr = '0;
        end else begin
            if (cmd_wr) begin
                // start goes back to word 0, otherwise advance by run bit
                if (!m_collecting && run) begin
                    m_addr = '0;
                end else if (run) begin
                    m_addr = m_addr + 1'b1;
                end
                m_collecting = run;
                m_pending = run ? (m_pending || trig) : 1'b0;
                stage_wen = run;
                for (int ch = 0; ch < num_chan; ch++) begin
                    stage_word[ch] = {1'b0, stamp, reg_wdata[15:0]};
                end
            end else if (take_sample) begin
                m_addr = m_addr + 1'b1;
                m_pending = 1'b0;
                stage_wen = 1'b1;
                for (int ch = 0; ch < 4; ch++) begin
                    stage_word[ch] = enc ? fb_in[ch] : {1'b1, stamp, fb_in[ch][15:0]};
                end
                // timestamp channel only used by encoder words
                stage_word[4] = enc ? {1'b1, stamp, 16'h0000} : 32'h0000_0000;
            end
            stage_addr = m_addr;
            m_fb_last = data_fb_wen;
        end
    end

    // ----------------------------------------------------------------------
    // compare mid cycle, where DUT outputs are settled
    // ----------------------------------------------------------------------

    always @(negedge clkbuffer) begin
        if (exp_valid) begin
            reads_done++;
            if (reg_rdata !== exp_rdata) begin
                mismatches++;
                $display("ERROR %0t: read addr %h expected %h got %h",
                         $time, exp_raddr, exp_rdata, reg_rdata);
            end
        end
        if (rst_n && (databuf_status !== status_of(m_collecting, m_addr))) begin
            mismatches++;
            $display("ERROR %0t: status expected %h got %h",
                     $time, status_of(m_collecting, m_addr), databuf_status);
        end
    end

endmodule

//--- testbench/tb_data_buffer.sv
`timescale 1ns/100ps

module tb_data_buffer;
    import databuf_pkg::*;

    localparam int buf_aw = 6;
    localparam int wait_limit = 40;

    typedef enum logic [2:0] {
        st_start, st_command, st_stop, st_pulse, st_cmd_fb, st_idle
    } step_kind_t;

    // value is the command value, or the high time of a feedback pulse
    typedef struct packed {
        step_kind_t  kind;
        logic        run;
        logic [3:0]  src;
        logic [15:0] value;
        logic [7:0]  reps;
    } step_t;

    localparam int num_steps = 17;
    localparam step_t steps [num_steps] = '{
        '{st_start,   1'b1, 4'd1, 16'h1a66, 8'd1},
        '{st_pulse,   1'b0, 4'd1, 16'd1,    8'd36},
        '{st_pulse,   1'b0, 4'd7, 16'd1,    8'd36},
        '{st_stop,    1'b0, 4'd7, 16'h1c88, 8'd1},
        '{st_pulse,   1'b0, 4'd2, 16'd1,    8'd3},
        '{st_stop,    1'b0, 4'd2, 16'h1d99, 8'd1},
        '{st_start,   1'b1, 4'd0, 16'h0a11, 8'd1},
        '{st_idle,    1'b0, 4'd0, 16'd0,    8'd2},
        '{st_pulse,   1'b0, 4'd1, 16'd1,    8'd6},
        '{st_pulse,   1'b0, 4'd2, 16'd3,    8'd1},
        '{st_command, 1'b1, 4'd2, 16'h0b22, 8'd1},
        '{st_cmd_fb,  1'b1, 4'd3, 16'h0c33, 8'd2},
        '{st_pulse,   1'b0, 4'd5, 16'd1,    8'd8},
        '{st_cmd_fb,  1'b1, 4'd6, 16'h0d44, 8'd1},
        '{st_stop,    1'b0, 4'd6, 16'h0e55, 8'd1},
        '{st_pulse,   1'b0, 4'd6, 16'd1,    8'd4},
        '{st_idle,    1'b0, 4'd0, 16'd0,    8'd3}
    };

    logic        clkbuffer = 1'b0;
    logic        rst_n;
    logic [31:0] ts;
    logic        data_fb_wen;
    logic [31:0] input_data1, input_data2, input_data3, input_data4;
    logic [3:0]  buffer_source;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    logic [15:0] databuf_status;
    logic [31:0] lfsr_state;
    int          errors;
    int          checked_reads;
    int          timeouts;

    always #2 clkbuffer = ~clkbuffer;

    // free running timestamp, crosses 16383 during the first run
    always @(posedge clkbuffer) begin
        #1;
        ts <= ts + 32'd1;
    end

    data_buffer_top #(.buf_aw(buf_aw)) i_data_buffer_top (
        .clkbuffer(clkbuffer), .rst_n(rst_n), .ts(ts), .data_fb_wen(data_fb_wen),
        .input_data1(input_data1), .input_data2(input_data2),
        .input_data3(input_data3), .input_data4(input_data4),
        .buffer_source(buffer_source), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .databuf_status(databuf_status)
    );

    databuf_checker #(.buf_aw(buf_aw)) i_checker (
        .clkbuffer(clkbuffer), .rst_n(rst_n), .ts(ts), .data_fb_wen(data_fb_wen),
        .input_data1(input_data1), .input_data2(input_data2),
        .input_data3(input_data3), .input_data4(input_data4),
        .buffer_source(buffer_source), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .databuf_status(databuf_status), .errors(errors), .checked(checked_reads)
    );

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return w;
    endfunction

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clkbuffer);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        int left;
        left = n;
        if (left > wait_limit) begin
            $display("idle wait of %0d cycles is longer than the %0d cycle limit", n, wait_limit);
            timeouts++;
            left = wait_limit;
        end
        while (left > 0) begin
            next_cycle();
            left--;
        end
    endtask

    task automatic wait_collecting(input logic want);
        int polls;
        polls = 0;
        while ((databuf_status[15] !== want) && (polls < wait_limit)) begin
            next_cycle();
            polls++;
        end
        if (databuf_status[15] !== want) begin
            $display("timeout: collecting flag did not go to %0b", want);
            timeouts++;
        end
    endtask

    task automatic load_inputs();
        input_data1 = lfsr_word();
        input_data2 = lfsr_word();
        input_data3 = lfsr_word();
        input_data4 = lfsr_word();
    endtask

    // command register write, optionally with a feedback edge in the same cycle
    task automatic write_command(input logic run, input logic [15:0] value, input logic fb);
        reg_waddr = {addr_main, 8'h00, off_dac_ctrl};
        reg_wdata = '0;
        reg_wdata[run_bit] = run;
        reg_wdata[15:0] = value;
        reg_wen = 1'b1;
        if (fb) begin
            load_inputs();
            data_fb_wen = 1'b1;
        end
        next_cycle();
        reg_wen = 1'b0;
        data_fb_wen = 1'b0;
        next_cycle();
    endtask

    task automatic feedback_pulse(input int high_cycles);
        load_inputs();
        data_fb_wen = 1'b1;
        idle_cycles(high_cycles);
        data_fb_wen = 1'b0;
        next_cycle();
    endtask

    task automatic apply_step(input step_t s);
        buffer_source = s.src;
        case (s.kind)
            st_start: begin
                write_command(1'b1, s.value, 1'b0);
                wait_collecting(1'b1);
            end
            st_stop: begin
                write_command(1'b0, s.value, 1'b0);
                wait_collecting(1'b0);
            end
            st_command: write_command(s.run, s.value, 1'b0);
            st_cmd_fb: write_command(s.run, s.value, 1'b1);
            st_pulse: feedback_pulse(int'(s.value));
            default: idle_cycles(1);
        endcase
    endtask

    // every word of every channel index, then register space
    task automatic readback_sweep();
        for (int ch = 0; ch < 8; ch++) begin
            for (int w = 0; w < 2**buf_aw; w++) begin
                reg_raddr = {1'b0, 3'(ch), 12'(w)};
                next_cycle();
            end
        end
        reg_raddr = {rd_status_sel, 3'b000, status_offset};
        next_cycle();
        reg_raddr = 16'h8010;
        next_cycle();
        reg_raddr = 16'h8abc;
        next_cycle();
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin
        rst_n = 1'b0;
        ts = 32'd16300;
        data_fb_wen = 1'b0;
        input_data1 = '0;
        input_data2 = '0;
        input_data3 = '0;
        input_data4 = '0;
        buffer_source = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen = 1'b0;
        // status read while collecting runs
        reg_raddr = {rd_status_sel, 3'b000, status_offset};
        lfsr_state = 32'hdc41;
        timeouts = 0;
        idle_cycles(3);
        rst_n = 1'b1;
        for (int i = 0; i < num_steps; i++) begin
            for (int r = 0; r < int'(steps[i].reps); r++) begin
                apply_step(steps[i]);
            end
        end
        readback_sweep();
        idle_cycles(2);
        $display("summary: %0d mismatches, %0d timeouts, %0d reads checked",
                 errors, timeouts, checked_reads);
        if ((errors == 0) && (timeouts == 0) && (checked_reads > 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // whole run guard in case the clock or a task stalls
    initial begin
        #20000;
        $display("timeout: simulation ran past its time limit");
        $display("summary: %0d mismatches, %0d timeouts, %0d reads checked",
                 errors, timeouts + 1, checked_reads);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- compile.f
src/databuf_pkg.sv
src/buffer_ctrl.sv
src/sample_packer.sv
src/sample_ram.sv
src/readback_mux.sv
src/data_buffer_top.sv
testbench/databuf_checker.sv
testbench/tb_data_buffer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_data_buffer -f compile.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1
